//--- tx_types_pkg.sv
//////////////////////////////
// lane tx common types
//////////////////////////////

package tx_types_pkg;

	localparam int bits_per_byte = 8;

	// one symbol on one lane
	typedef logic [bits_per_byte-1:0] lane_byte_t;

	// prbs11 shift register
	typedef logic [10:0] prbs_state_t;

	// long enough for a full slos set
	typedef logic [11:0] bit_cnt_t;

	// ordered-set select from the link training fsm
	// codes 4..7 and 9..15 are treated as unsupported
	typedef enum logic [3:0] {
		sel_slos1    = 4'd0,
		sel_slos2    = 4'd1,
		sel_ts1_gen3 = 4'd2,
		sel_ts2_gen3 = 4'd3,
		sel_data     = 4'd8
	} os_sel_t;

endpackage

//--- os_const_pkg.sv
//////////////////////////////
// ordered set constants
//////////////////////////////

package os_const_pkg;

	import tx_types_pkg::*;

	//////////////////////////////
	// prbs11 for slos
	//////////////////////////////

	localparam prbs_state_t prbs_seed_default = 11'b100_0000_0000;

	// x^11 + x^9 + 1, fed back into bit 0
	localparam int prbs_tap_hi = 10;
	localparam int prbs_tap_lo = 8;

	localparam int slos_bits = 2048; // bits per slos set

	//////////////////////////////
	// gen3 training sets
	//////////////////////////////

	localparam int ts_gen3_bits = 64;

	typedef logic [ts_gen3_bits-1:0] ts_pattern_t;

	// lane 1 differs in the second byte (lane number)
	localparam ts_pattern_t ts1_lane0 = 64'h0100_0000_0400_98F2;
	localparam ts_pattern_t ts1_lane1 = 64'h0101_0000_0400_98F2;
	localparam ts_pattern_t ts2_lane0 = 64'h0100_0000_0400_64F2;
	localparam ts_pattern_t ts2_lane1 = 64'h0101_0000_0400_64F2;

endpackage

//--- os_stream_if.sv
//////////////////////////////
// lane bit stream
//////////////////////////////

interface os_stream_if;

	logic bit_l0;    // next bit for lane 0
	logic bit_l1;    // next bit for lane 1
	logic shift_en;  // bits above are valid this cycle
	logic restart;   // clear shift regs and bit count
	logic data_mode; // forward transport data instead

	modport ctrl (
		output bit_l0,
		output bit_l1,
		output shift_en,
		output restart,
		output data_mode
	);

	modport ser (
		input bit_l0,
		input bit_l1,
		input shift_en,
		input restart,
		input data_mode
	);

endinterface

//--- prbs11_gen.sv
//////////////////////////////
// prbs11 generator
//////////////////////////////

module prbs11_gen
	import tx_types_pkg::*, os_const_pkg::*;
#(
	parameter prbs_state_t slos_seed = prbs_seed_default
) (
	input  logic fsm_clk,
	input  logic rst,
	input  logic prbs_load,
	input  logic prbs_step,
	output logic prbs_bit
);

	prbs_state_t lfsr;

	assign prbs_bit = lfsr[0];

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			lfsr <= slos_seed;
		end else if (prbs_load) begin
			lfsr <= slos_seed; // wins over a step in the same cycle
		end else if (prbs_step) begin
			lfsr <= {lfsr[9:0], lfsr[prbs_tap_hi] ^ lfsr[prbs_tap_lo]}; // toward msb
		end
	end

endmodule

//--- ts_pattern_src.sv
//////////////////////////////
// gen3 ts bit source
//////////////////////////////

module ts_pattern_src
	import tx_types_pkg::*, os_const_pkg::*;
(
	input  logic fsm_clk,
	input  logic rst,
	input  logic pat_start,
	input  logic pat_step,
	input  logic pat_sel,
	output logic pat_l0,
	output logic pat_l1,
	output logic pat_last
);

	localparam int idx_w = $clog2(ts_gen3_bits);

	logic [idx_w-1:0] pat_idx; // counts down, msb goes first
	ts_pattern_t      lane0_pat;
	ts_pattern_t      lane1_pat;

	// pat_sel low is ts1, high is ts2
	assign lane0_pat = pat_sel ? ts2_lane0 : ts1_lane0;
	assign lane1_pat = pat_sel ? ts2_lane1 : ts1_lane1;

	assign pat_l0   = lane0_pat[pat_idx];
	assign pat_l1   = lane1_pat[pat_idx];
	assign pat_last = (pat_idx == '0);

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			pat_idx <= idx_w'(ts_gen3_bits - 1);
		end else if (pat_start) begin
			pat_idx <= idx_w'(ts_gen3_bits - 1);
		end else if (pat_step) begin
			pat_idx <= pat_idx - idx_w'(1);
		end
	end

endmodule

//--- os_tx_ctrl.sv
//////////////////////////////
// ordered set sequencer
//////////////////////////////

module os_tx_ctrl
	import tx_types_pkg::*, os_const_pkg::*;
(
	input  logic        fsm_clk,
	input  logic        rst,
	input  os_sel_t     d_sel,
	input  logic        prbs_bit,
	input  logic        pat_l0,
	input  logic        pat_l1,
	input  logic        pat_last,
	output logic        prbs_load,
	output logic        prbs_step,
	output logic        pat_start,
	output logic        pat_step,
	output logic        pat_sel,
	output logic        os_sent,
	output logic        tx_lanes_on,
	os_stream_if.ctrl   strm
);

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_slos,
		st_ts,
		st_data
	} ctrl_state_t;

	ctrl_state_t state;
	ctrl_state_t next_state;
	ctrl_state_t entry_state;
	os_sel_t     d_sel_q;
	bit_cnt_t    slos_cnt;
	logic        sel_change;
	logic        sel_is_slos;
	logic        slos_inv;
	logic        last_bit;

	assign sel_change  = (d_sel != d_sel_q);
	assign sel_is_slos = (d_sel_q == sel_slos1) || (d_sel_q == sel_slos2);
	assign slos_inv    = (d_sel_q == sel_slos2); // slos2 is slos1 inverted
	assign pat_sel     = (d_sel_q == sel_ts2_gen3);

	assign last_bit = ((state == st_slos) && (slos_cnt == bit_cnt_t'(slos_bits - 1))) ||
	                  ((state == st_ts) && pat_last);

	// where a freshly selected d_sel leads
	always_comb begin
		case (d_sel)
			sel_slos1, sel_slos2, sel_ts1_gen3, sel_ts2_gen3: entry_state = st_start;
			sel_data: entry_state = st_data;
			default:  entry_state = st_idle;
		endcase
	end

	always_comb begin
		if (sel_change || (state == st_idle)) begin
			next_state = entry_state;
		end else if (state == st_start) begin
			next_state = sel_is_slos ? st_slos : st_ts;
		end else begin
			next_state = state; // sets repeat back to back
		end
	end

	//////////////////////////////
	// stream and source controls
	//////////////////////////////

	always_comb begin
		strm.bit_l0    = 1'b0;
		strm.bit_l1    = 1'b0;
		strm.shift_en  = 1'b0;
		strm.restart   = 1'b0;
		strm.data_mode = 1'b0;
		prbs_load      = 1'b0;
		prbs_step      = 1'b0;
		pat_start      = 1'b0;
		pat_step       = 1'b0;
		case (state)
			st_idle: strm.restart = 1'b1; // held, keeps lanes at zero
			st_start: begin
				strm.restart = 1'b1;
				prbs_load    = sel_is_slos;
				pat_start    = !sel_is_slos;
			end
			st_slos: begin
				strm.shift_en = 1'b1;
				strm.bit_l0   = prbs_bit ^ slos_inv;
				strm.bit_l1   = prbs_bit ^ slos_inv; // same on both lanes
				prbs_step     = 1'b1;
				prbs_load     = last_bit; // reseed for the next repetition
			end
			st_ts: begin
				strm.shift_en = 1'b1;
				strm.bit_l0   = pat_l0;
				strm.bit_l1   = pat_l1;
				pat_step      = 1'b1;
				pat_start     = last_bit;
			end
			st_data: strm.data_mode = 1'b1;
			default: strm.restart = 1'b1;
		endcase
	end

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			state       <= st_idle;
			d_sel_q     <= sel_slos1;
			slos_cnt    <= '0;
			os_sent     <= 1'b0;
			tx_lanes_on <= 1'b0;
		end else begin
			state   <= next_state;
			d_sel_q <= d_sel;
			os_sent <= last_bit; // same edge as the final byte
			if ((state == st_slos) && !last_bit) begin
				slos_cnt <= slos_cnt + bit_cnt_t'(1);
			end else begin
				slos_cnt <= '0;
			end
			// first slos byte goes out on this edge
			if ((state == st_slos) && (slos_cnt[2:0] == 3'(bits_per_byte - 1))) begin
				tx_lanes_on <= 1'b1;
			end
		end
	end

endmodule

//--- lane_serializer.sv
//////////////////////////////
// two lane byte assembly
//////////////////////////////

module lane_serializer
	import tx_types_pkg::*;
(
	input  logic        fsm_clk,
	input  logic        rst,
	input  lane_byte_t  transport_layer_data_in,
	output lane_byte_t  lane_0_tx,
	output lane_byte_t  lane_1_tx,
	os_stream_if.ser    strm
);

	lane_byte_t sr_l0;
	lane_byte_t sr_l1;
	logic [2:0] bit_cnt; // bits gathered in the current byte
	lane_byte_t next_l0;
	lane_byte_t next_l1;
	logic       byte_done;

	// shift regs with this cycle's bit already in the lsb
	assign next_l0   = {sr_l0[bits_per_byte-2:0], strm.bit_l0};
	assign next_l1   = {sr_l1[bits_per_byte-2:0], strm.bit_l1};
	assign byte_done = (bit_cnt == 3'(bits_per_byte - 1));

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			sr_l0     <= '0;
			sr_l1     <= '0;
			bit_cnt   <= '0;
			lane_0_tx <= '0;
			lane_1_tx <= '0;
		end else if (strm.data_mode) begin
			// transport layer traffic, lane 1 unused
			lane_0_tx <= transport_layer_data_in;
			lane_1_tx <= '0;
			bit_cnt   <= '0;
		end else if (strm.restart) begin
			// idle holds restart, so lanes stay quiet
			sr_l0     <= '0;
			sr_l1     <= '0;
			bit_cnt   <= '0;
			lane_0_tx <= '0;
			lane_1_tx <= '0;
		end else if (strm.shift_en) begin
			sr_l0   <= next_l0;
			sr_l1   <= next_l1;
			bit_cnt <= bit_cnt + 3'd1; // wraps every byte
			if (byte_done) begin
				lane_0_tx <= next_l0; // first bit ends up in the msb
				lane_1_tx <= next_l1;
			end
		end
	end

endmodule

//--- lane_tx_top.sv
//////////////////////////////
// lane init transmitter
//////////////////////////////

module lane_tx_top
	import tx_types_pkg::*, os_const_pkg::*;
#(
	parameter prbs_state_t slos_seed = prbs_seed_default
) (
	input  logic       fsm_clk,
	input  logic       rst,
	input  os_sel_t    d_sel,
	input  lane_byte_t transport_layer_data_in,
	output lane_byte_t lane_0_tx,
	output lane_byte_t lane_1_tx,
	output logic       os_sent,
	output logic       tx_lanes_on
);

	logic prbs_load;
	logic prbs_step;
	logic prbs_bit;
	logic pat_start;
	logic pat_step;
	logic pat_sel;
	logic pat_l0;
	logic pat_l1;
	logic pat_last;

	os_stream_if strm ();

	os_tx_ctrl i_os_tx_ctrl (
		.fsm_clk     (fsm_clk),
		.rst         (rst),
		.d_sel       (d_sel),
		.prbs_bit    (prbs_bit),
		.pat_l0      (pat_l0),
		.pat_l1      (pat_l1),
		.pat_last    (pat_last),
		.prbs_load   (prbs_load),
		.prbs_step   (prbs_step),
		.pat_start   (pat_start),
		.pat_step    (pat_step),
		.pat_sel     (pat_sel),
		.os_sent     (os_sent),
		.tx_lanes_on (tx_lanes_on),
		.strm        (strm.ctrl)
	);

	prbs11_gen #(
		.slos_seed (slos_seed)
	) i_prbs11_gen (
		.fsm_clk   (fsm_clk),
		.rst       (rst),
		.prbs_load (prbs_load),
		.prbs_step (prbs_step),
		.prbs_bit  (prbs_bit)
	);

	ts_pattern_src i_ts_pattern_src (
		.fsm_clk   (fsm_clk),
		.rst       (rst),
		.pat_start (pat_start),
		.pat_step  (pat_step),
		.pat_sel   (pat_sel),
		.pat_l0    (pat_l0),
		.pat_l1    (pat_l1),
		.pat_last  (pat_last)
	);

	lane_serializer i_lane_serializer (
		.fsm_clk                 (fsm_clk),
		.rst                     (rst),
		.transport_layer_data_in (transport_layer_data_in),
		.lane_0_tx               (lane_0_tx),
		.lane_1_tx               (lane_1_tx),
		.strm                    (strm.ser)
	);

endmodule

//--- tb_lane_tx.sv
//////////////////////////////
// lane tx testbench
//////////////////////////////

module tb_lane_tx
	import tx_types_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	// expected prbs seed and gen3 ts patterns
	localparam prbs_state_t ref_seed = 11'b100_0000_0000;
	localparam logic [63:0] ref_ts1_l0 = 64'h0100_0000_0400_98F2;
	localparam logic [63:0] ref_ts1_l1 = 64'h0101_0000_0400_98F2;
	localparam logic [63:0] ref_ts2_l0 = 64'h0100_0000_0400_64F2;
	localparam logic [63:0] ref_ts2_l1 = 64'h0101_0000_0400_64F2;

	logic       fsm_clk;
	logic       rst;
	os_sel_t    d_sel;
	lane_byte_t transport_layer_data_in;
	lane_byte_t lane_0_tx;
	lane_byte_t lane_1_tx;
	logic       os_sent;
	logic       tx_lanes_on;

	int seed;
	int byte_errors = 0;
	int flag_errors = 0;
	int timeouts    = 0;

	lane_tx_top i_lane_tx_top (
		.fsm_clk                 (fsm_clk),
		.rst                     (rst),
		.d_sel                   (d_sel),
		.transport_layer_data_in (transport_layer_data_in),
		.lane_0_tx               (lane_0_tx),
		.lane_1_tx               (lane_1_tx),
		.os_sent                 (os_sent),
		.tx_lanes_on             (tx_lanes_on)
	);

	initial begin
		fsm_clk = 1'b0;
		forever #5 fsm_clk = ~fsm_clk;
	end

	//////////////////////////////
	// compare and wait helpers
	//////////////////////////////

	task automatic check_byte(input string name, input lane_byte_t exp, input lane_byte_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			byte_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			flag_errors++;
		end
	endtask

	// returns one ns after the edge that raised os_sent
	task automatic wait_os_sent(input string name, input int limit, output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && (n < limit)) begin
			@(posedge fsm_clk);
			#1;
			n++;
			if (os_sent === 1'b1) ok = 1'b1;
		end
		if (!ok) begin
			$display("%s: os_sent did not pulse within %0d cycles", name, limit);
			timeouts++;
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic run_reset();
		int n;
		for (n = 0; n < 12; n++) begin
			@(posedge fsm_clk);
			#1;
			if (n == 7) rst = 1'b1; // 8 cycles in reset
			check_byte("reset lane_0_tx", 8'h00, lane_0_tx);
			check_byte("reset lane_1_tx", 8'h00, lane_1_tx);
			check_flag("reset os_sent", 1'b0, os_sent);
			check_flag("reset tx_lanes_on", 1'b0, tx_lanes_on);
		end
	endtask

	task automatic run_slos(input string name, input os_sel_t sel, input logic inv);
		lane_byte_t  exp_q[$];
		lane_byte_t  b;
		prbs_state_t lfsr;
		bit          ok;
		int          i;
		int          j;
		// one full set from the prbs11 model, first bit into the msb
		lfsr = ref_seed;
		for (i = 0; i < 256; i++) begin
			b = '0;
			for (j = 0; j < 8; j++) begin
				b    = {b[6:0], lfsr[0] ^ inv};
				lfsr = {lfsr[9:0], lfsr[10] ^ lfsr[8]};
			end
			exp_q.push_back(b);
		end
		@(posedge fsm_clk);
		#1;
		d_sel = sel;
		wait_os_sent(name, 2100, ok);
		if (ok) begin
			// second repetition, os_sent only on its last cycle
			for (i = 0; i < 2048; i++) begin
				@(posedge fsm_clk);
				#1;
				if ((i % 8) == 7) begin
					b = exp_q.pop_front();
					check_byte({name, " lane_0_tx"}, b, lane_0_tx);
					check_byte({name, " lane_1_tx"}, b, lane_1_tx);
				end
				check_flag({name, " os_sent"}, (i == 2047), os_sent);
			end
			check_flag({name, " tx_lanes_on"}, 1'b1, tx_lanes_on);
		end
	endtask

	task automatic run_ts(input string name, input os_sel_t sel,
			input logic [63:0] pat0, input logic [63:0] pat1);
		logic [63:0] sh0;
		logic [63:0] sh1;
		bit          ok;
		int          i;
		sh0 = pat0;
		sh1 = pat1;
		@(posedge fsm_clk);
		#1;
		d_sel = sel;
		wait_os_sent(name, 100, ok);
		if (ok) begin
			for (i = 0; i < 64; i++) begin
				@(posedge fsm_clk);
				#1;
				if ((i % 8) == 7) begin
					check_byte({name, " lane_0_tx"}, sh0[63:56], lane_0_tx);
					check_byte({name, " lane_1_tx"}, sh1[63:56], lane_1_tx);
					sh0 = sh0 << 8; // next byte down, msb first
					sh1 = sh1 << 8;
				end
				check_flag({name, " os_sent"}, (i == 63), os_sent);
			end
		end
	endtask

	task automatic run_data();
		logic [31:0] rnd;
		lane_byte_t  prev;
		int          n;
		@(posedge fsm_clk);
		#1;
		d_sel = sel_data;
		repeat (2) @(posedge fsm_clk);
		#1;
		rnd = $random(seed);
		transport_layer_data_in = rnd[7:0];
		prev = transport_layer_data_in;
		for (n = 0; n < 64; n++) begin
			@(posedge fsm_clk);
			#1;
			check_byte("data lane_0_tx", prev, lane_0_tx); // one cycle late
			check_byte("data lane_1_tx", 8'h00, lane_1_tx);
			check_flag("data os_sent", 1'b0, os_sent);
			rnd = $random(seed);
			transport_layer_data_in = rnd[7:0];
			prev = transport_layer_data_in;
		end
		transport_layer_data_in = '0;
	endtask

	task automatic run_unsupported();
		int c;
		int n;
		for (c = 4; c < 8; c++) begin
			@(posedge fsm_clk);
			#1;
			d_sel = os_sel_t'(4'(c));
			repeat (3) @(posedge fsm_clk);
			for (n = 0; n < 100; n++) begin
				@(posedge fsm_clk);
				#1;
				check_byte("unsupported lane_0_tx", 8'h00, lane_0_tx);
				check_byte("unsupported lane_1_tx", 8'h00, lane_1_tx);
				check_flag("unsupported os_sent", 1'b0, os_sent);
				check_flag("unsupported tx_lanes_on", 1'b1, tx_lanes_on); // still on since slos
			end
		end
	endtask

	initial begin
		seed = 32'h3dc9;
		rst  = 1'b0;
		d_sel = os_sel_t'(4'hf); // quiet select while in reset
		transport_layer_data_in = '0;

		run_reset();
		run_slos("slos1", sel_slos1, 1'b0);
		run_slos("slos2", sel_slos2, 1'b1);
		run_ts("ts1_gen3", sel_ts1_gen3, ref_ts1_l0, ref_ts1_l1);
		run_ts("ts2_gen3", sel_ts2_gen3, ref_ts2_l0, ref_ts2_l1);
		run_data();
		run_unsupported();

		$display("byte errors %0d, flag errors %0d, timeouts %0d",
			byte_errors, flag_errors, timeouts);
		if ((byte_errors + flag_errors + timeouts) == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
tx_types_pkg.sv
os_const_pkg.sv
os_stream_if.sv
prbs11_gen.sv
ts_pattern_src.sv
os_tx_ctrl.sv
lane_serializer.sv
lane_tx_top.sv
tb_lane_tx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the lane tx testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_lane_tx -f filelist.f -o sim_lane_tx &&
	./obj_dir/sim_lane_tx | tee /dev/stderr | grep "TESTS PASSED" > /dev/null &&
	echo "simulation ok" && exit 0 ||
	{ echo "simulation failed"; exit 1; }
